/* source/tbu_pkg.sv */
package tbu_pkg;

  // Trellis size
  localparam int num_states = 16;
  localparam int state_w    = 4;   // Bits per state index

  // Traceback depth and output block length
  localparam int x_min   = 6;      // Stages walked back before output starts
  localparam int blk_len = 10;     // Decided bits per traceback

  // Survivor memory geometry
  localparam int mem_depth = 32;   // Stages held in the circular buffer
  localparam int entry_w   = state_w + 1;  // Predecessor plus decision bit

  // One trellis state index
  typedef logic [state_w-1:0] state_t;

  // Predecessors of all states, state s in slice s
  typedef logic [num_states*state_w-1:0] stage_prev_t;

  // Decision bits of all states, state s in bit s
  typedef logic [num_states-1:0] stage_desc_t;

  // Survivor memory address
  typedef logic [$clog2(mem_depth)-1:0] mem_addr_t;

  // One stored stage, entry s is {decision, predecessor}
  typedef logic [num_states*entry_w-1:0] mem_word_t;

  // Position inside an output block
  typedef logic [$clog2(blk_len)-1:0] blk_idx_t;

  // Traceback FSM
  typedef enum logic [1:0] {
    tb_idle,
    tb_discard,
    tb_emit
  } tb_state_e;

endpackage

/* source/survivor_write.sv */
`timescale 1ns/1ns

module survivor_write (
  input  logic                 clk,
  input  logic                 sys_rst,
  input  logic                 in_valid,
  input  tbu_pkg::stage_prev_t prev_state,
  input  tbu_pkg::stage_desc_t decision,
  output logic                 wr_en,
  output tbu_pkg::mem_addr_t   wr_addr,
  output tbu_pkg::mem_word_t   wr_data,
  output logic                 tb_start,
  output tbu_pkg::mem_addr_t   tb_addr
);

  localparam int fill_len = tbu_pkg::x_min + tbu_pkg::blk_len;

  tbu_pkg::mem_addr_t wr_ptr;
  tbu_pkg::mem_word_t packed_word;
  tbu_pkg::blk_idx_t  blk_cnt;                // Stages since last start, once filled
  logic [$clog2(fill_len+1)-1:0] stage_cnt;   // Saturates at fill_len
  logic               filled;
  logic               fire;
  logic               start_pend;             // Start is due once the write lands

  // Interleave predecessor and decision bit per state
  always_comb begin
    for (int s = 0; s < tbu_pkg::num_states; s++) begin
      packed_word[s*tbu_pkg::entry_w +: tbu_pkg::entry_w] =
        {decision[s], prev_state[s*tbu_pkg::state_w +: tbu_pkg::state_w]};
    end
  end

  assign filled = (stage_cnt == fill_len);
  assign fire   = in_valid && (filled ? (blk_cnt == tbu_pkg::blk_idx_t'(tbu_pkg::blk_len - 1))
                                      : (stage_cnt == fill_len - 1));

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      wr_en      <= 1'b0;
      wr_ptr     <= '0;
      stage_cnt  <= '0;
      blk_cnt    <= '0;
      start_pend <= 1'b0;
      tb_start   <= 1'b0;
    end else begin
      wr_en      <= in_valid;
      start_pend <= fire;
      tb_start   <= start_pend;  // One cycle after the write
      if (in_valid) begin
        wr_ptr <= (wr_ptr == tbu_pkg::mem_addr_t'(tbu_pkg::mem_depth - 1)) ? '0 : wr_ptr + 1'b1;
        if (!filled) begin
          stage_cnt <= stage_cnt + 1'b1;
        end else if (blk_cnt == tbu_pkg::blk_idx_t'(tbu_pkg::blk_len - 1)) begin
          blk_cnt <= '0;
        end else begin
          blk_cnt <= blk_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      wr_addr <= wr_ptr;
      wr_data <= packed_word;
    end
    if (start_pend) begin
      tb_addr <= wr_addr;  // Newest stage, traceback begins here
    end
  end

endmodule

/* source/survivor_mem.sv */
`timescale 1ns/1ns

module survivor_mem (
  input  logic               clk,
  input  logic               wr_en,
  input  tbu_pkg::mem_addr_t wr_addr,
  input  tbu_pkg::mem_word_t wr_data,
  input  tbu_pkg::mem_addr_t rd_addr,
  output tbu_pkg::mem_word_t rd_data
);

  // Circular store, one word per trellis stage
  tbu_pkg::mem_word_t mem [tbu_pkg::mem_depth];

  // Write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read port, data one cycle after the address
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* source/traceback_engine.sv */
`timescale 1ns/1ns

module traceback_engine (
  input  logic               clk,
  input  logic               sys_rst,
  input  logic               tb_start,
  input  tbu_pkg::mem_addr_t tb_addr,
  input  tbu_pkg::mem_word_t rd_data,
  output tbu_pkg::mem_addr_t rd_addr,
  output logic               bit_valid,
  output logic               bit_data
);

  tbu_pkg::tb_state_e fsm;
  tbu_pkg::state_t    cur_state;   // State whose entry is selected this step
  tbu_pkg::mem_addr_t addr_q;      // Next stage to read
  tbu_pkg::mem_addr_t addr_prev;
  tbu_pkg::blk_idx_t  step_cnt;
  logic [tbu_pkg::entry_w-1:0] cur_entry;

  // The start address goes out directly so the first word returns next cycle
  assign rd_addr = (fsm == tbu_pkg::tb_idle) ? tb_addr : addr_q;

  // Walk backwards through the circular buffer
  assign addr_prev = (rd_addr == '0) ? tbu_pkg::mem_addr_t'(tbu_pkg::mem_depth - 1)
                                     : rd_addr - 1'b1;

  assign cur_entry = rd_data[int'(cur_state)*tbu_pkg::entry_w +: tbu_pkg::entry_w];

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      fsm       <= tbu_pkg::tb_idle;
      cur_state <= '0;
      addr_q    <= '0;
      step_cnt  <= '0;
      bit_valid <= 1'b0;
    end else begin
      bit_valid <= 1'b0;
      case (fsm)
        tbu_pkg::tb_idle: begin
          if (tb_start) begin
            fsm       <= tbu_pkg::tb_discard;
            cur_state <= '0;  // Every traceback begins in state 0
            addr_q    <= addr_prev;
            step_cnt  <= '0;
          end
        end
        tbu_pkg::tb_discard: begin
          cur_state <= cur_entry[tbu_pkg::state_w-1:0];
          addr_q    <= addr_prev;
          if (step_cnt == tbu_pkg::blk_idx_t'(tbu_pkg::x_min - 1)) begin
            fsm      <= tbu_pkg::tb_emit;
            step_cnt <= '0;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        tbu_pkg::tb_emit: begin
          cur_state <= cur_entry[tbu_pkg::state_w-1:0];
          addr_q    <= addr_prev;
          bit_valid <= 1'b1;  // Newest bit of the block first
          if (step_cnt == tbu_pkg::blk_idx_t'(tbu_pkg::blk_len - 1)) begin
            fsm      <= tbu_pkg::tb_idle;
            step_cnt <= '0;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        default: fsm <= tbu_pkg::tb_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fsm == tbu_pkg::tb_emit) begin
      bit_data <= cur_entry[tbu_pkg::state_w];  // Decision bit sits above the predecessor
    end
  end

endmodule

/* source/bit_reorder.sv */
`timescale 1ns/1ns

module bit_reorder (
  input  logic clk,
  input  logic sys_rst,
  input  logic bit_valid,
  input  logic bit_data,
  output logic out_valid,
  output logic out_bit
);

  logic [tbu_pkg::blk_len-1:0] bank [2];
  logic              wr_bank;
  logic              rd_bank;
  logic              rd_active;
  tbu_pkg::blk_idx_t wr_idx;   // Fills downward, newest bit at the top
  tbu_pkg::blk_idx_t rd_idx;   // Drains upward, oldest bit first

  assign out_valid = rd_active;
  assign out_bit   = bank[rd_bank][rd_idx];

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      wr_bank   <= 1'b0;
      wr_idx    <= tbu_pkg::blk_idx_t'(tbu_pkg::blk_len - 1);
      rd_bank   <= 1'b0;
      rd_idx    <= '0;
      rd_active <= 1'b0;
    end else begin
      if (rd_active) begin
        if (rd_idx == tbu_pkg::blk_idx_t'(tbu_pkg::blk_len - 1)) begin
          rd_active <= 1'b0;
        end else begin
          rd_idx <= rd_idx + 1'b1;
        end
      end
      // A full bank starts draining next cycle, the other one takes new bits
      if (bit_valid) begin
        if (wr_idx == '0) begin
          wr_idx    <= tbu_pkg::blk_idx_t'(tbu_pkg::blk_len - 1);
          wr_bank   <= ~wr_bank;
          rd_bank   <= wr_bank;
          rd_idx    <= '0;
          rd_active <= 1'b1;
        end else begin
          wr_idx <= wr_idx - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bit_valid) begin
      bank[wr_bank][wr_idx] <= bit_data;
    end
  end

endmodule

/* source/tbu_top.sv */
`timescale 1ns/1ns

module tbu_top (
  input  logic                 clk,
  input  logic                 sys_rst,
  input  logic                 in_valid,    // At most every other cycle
  input  tbu_pkg::stage_prev_t prev_state,
  input  tbu_pkg::stage_desc_t decision,
  output logic                 out_valid,
  output logic                 out_bit
);

  logic               wr_en;
  tbu_pkg::mem_addr_t wr_addr;
  tbu_pkg::mem_word_t wr_data;
  logic               tb_start;
  tbu_pkg::mem_addr_t tb_addr;
  tbu_pkg::mem_addr_t rd_addr;
  tbu_pkg::mem_word_t rd_data;
  logic               bit_valid;
  logic               bit_data;

  survivor_write u_write (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .in_valid   (in_valid),
    .prev_state (prev_state),
    .decision   (decision),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .tb_start   (tb_start),
    .tb_addr    (tb_addr)
  );

  survivor_mem u_mem (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  traceback_engine u_engine (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .tb_start  (tb_start),
    .tb_addr   (tb_addr),
    .rd_data   (rd_data),
    .rd_addr   (rd_addr),
    .bit_valid (bit_valid),
    .bit_data  (bit_data)
  );

  bit_reorder u_reorder (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .bit_valid (bit_valid),
    .bit_data  (bit_data),
    .out_valid (out_valid),
    .out_bit   (out_bit)
  );

endmodule

/* bench/tbu_props.sv */
`timescale 1ns/1ns

module tbu_props (
  input logic clk,
  input logic sys_rst,
  input logic in_valid,
  input logic tb_start,
  input logic bit_valid,
  input logic out_valid
);

  int   run_len;       // Consecutive cycles with out_valid high
  logic tb_busy;       // Traceback started and not yet done emitting
  logic bit_valid_q;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      run_len     <= 0;
      tb_busy     <= 1'b0;
      bit_valid_q <= 1'b0;
    end else begin
      run_len     <= out_valid ? run_len + 1 : 0;
      bit_valid_q <= bit_valid;
      if (tb_start) begin
        tb_busy <= 1'b1;
      end else if (bit_valid_q && !bit_valid) begin
        tb_busy <= 1'b0;   // Last bit of the block has gone out
      end
    end
  end

  a_rst_quiet: assert property (@(posedge clk) sys_rst |=> !out_valid)
    else $error("out_valid high while reset is applied");

  a_in_spacing: assert property (@(posedge clk) disable iff (sys_rst) in_valid |=> !in_valid)
    else $error("in_valid high in two consecutive cycles");

  a_out_short: assert property (@(posedge clk) disable iff (sys_rst)
      $fell(out_valid) |-> run_len == tbu_pkg::blk_len)
    else $error("out_valid burst shorter than one block");

  a_out_long: assert property (@(posedge clk) disable iff (sys_rst)
      out_valid |-> run_len < tbu_pkg::blk_len)
    else $error("out_valid burst longer than one block");

  a_bit_source: assert property (@(posedge clk) disable iff (sys_rst)
      $rose(bit_valid) |-> tb_busy)
    else $error("bit_valid rose with no traceback started");

endmodule

/* bench/tbu_tb.sv */
`timescale 1ns/1ns

module tbu_tb;

  localparam int fill_len    = tbu_pkg::x_min + tbu_pkg::blk_len;
  localparam int n_long      = 200;
  localparam int n_tight     = 56;
  localparam int n_pre_reset = 26;   // Block 0 drains and block 1 is traced back when reset hits
  localparam int quiet_len   = 25;   // Idle cycles that must stay free of extra bits
  localparam int stages_sent = fill_len + n_long + n_tight + n_pre_reset + fill_len;
  localparam int cycle_limit = 6 * stages_sent + 200;

  logic                 clk;
  logic                 sys_rst;
  logic                 in_valid;
  tbu_pkg::stage_prev_t prev_state;
  tbu_pkg::stage_desc_t decision;
  logic                 out_valid;
  logic                 out_bit;

  integer seed;
  int     cycle_cnt;
  string  test_name;
  int     test_errs;
  int     tests_run;
  int     tests_failed;
  int     errs_total;

  tbu_pkg::stage_prev_t sent_prev[$];   // Every stage sent since the last reset
  tbu_pkg::stage_desc_t sent_desc[$];
  logic                 got_bits[$];
  logic                 exp_bits[$];

  tbu_top i_dut (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .in_valid   (in_valid),
    .prev_state (prev_state),
    .decision   (decision),
    .out_valid  (out_valid),
    .out_bit    (out_bit)
  );

  bind tbu_top tbu_props i_props (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .in_valid  (in_valid),
    .tb_start  (tb_start),
    .bit_valid (bit_valid),
    .out_valid (out_valid)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  // Outputs only move on the rising edge, so the falling edge sees settled values
  always @(negedge clk) begin
    if (!sys_rst && out_valid) begin
      got_bits.push_back(out_bit);
    end
  end

  task automatic reset_dut();
    @(negedge clk);
    sys_rst  = 1'b1;
    in_valid = 1'b0;
    repeat (5) @(negedge clk);
    sent_prev.delete();
    sent_desc.delete();
    got_bits.delete();
    sys_rst = 1'b0;
  endtask

  task automatic send_stream(input int n, input bit tight);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    int          gap;
    for (int i = 0; i < n; i++) begin
      r0  = $random(seed);
      r1  = $random(seed);
      r2  = $random(seed);
      gap = tight ? 2 : 2 + int'(r2[17:16]);   // 2 to 5 cycles between stages
      @(negedge clk);
      in_valid   = 1'b1;
      prev_state = {r0, r1};
      decision   = r2[15:0];
      sent_prev.push_back({r0, r1});
      sent_desc.push_back(r2[15:0]);
      @(negedge clk);
      in_valid = 1'b0;
      repeat (gap - 2) @(negedge clk);
    end
  endtask

  // Reference traceback for block k, starting in state 0 at its newest stage
  function automatic void model_block(input int k);
    int                   s;
    tbu_pkg::state_t      st;
    tbu_pkg::stage_prev_t prev_w;
    tbu_pkg::stage_desc_t desc_w;
    logic                 newest_first[$];
    s  = k * tbu_pkg::blk_len + fill_len - 1;
    st = '0;
    for (int j = 0; j < tbu_pkg::x_min; j++) begin
      prev_w = sent_prev[s];
      st     = prev_w[int'(st) * tbu_pkg::state_w +: tbu_pkg::state_w];
      s--;
    end
    for (int m = 0; m < tbu_pkg::blk_len; m++) begin
      prev_w = sent_prev[s];
      desc_w = sent_desc[s];
      newest_first.push_back(desc_w[st]);
      st = prev_w[int'(st) * tbu_pkg::state_w +: tbu_pkg::state_w];
      s--;
    end
    for (int i = tbu_pkg::blk_len - 1; i >= 0; i--) begin
      exp_bits.push_back(newest_first[i]);
    end
  endfunction

  function automatic int expected_blocks(input int n);
    return (n >= fill_len) ? (n - tbu_pkg::x_min) / tbu_pkg::blk_len : 0;
  endfunction

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s: %s expected %b, actual %b", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("error %s: %s expected %0d, actual %0d", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic compare_output();
    int n;
    exp_bits.delete();
    for (int k = 0; k < expected_blocks(sent_prev.size()); k++) begin
      model_block(k);
    end
    while (got_bits.size() < exp_bits.size()) @(negedge clk);
    repeat (quiet_len) @(negedge clk);
    check_count("bit count", exp_bits.size(), got_bits.size());
    n = (got_bits.size() < exp_bits.size()) ? got_bits.size() : exp_bits.size();
    for (int i = 0; i < n; i++) begin
      check_bit($sformatf("bit %0d", i), exp_bits[i], got_bits[i]);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    errs_total += test_errs;
    if (test_errs == 0) begin
      $display("test %s: pass", test_name);
    end else begin
      $display("test %s: FAIL with %0d errors", test_name, test_errs);
      tests_failed++;
    end
  endtask

  initial begin
    clk          = 1'b0;
    sys_rst      = 1'b1;
    in_valid     = 1'b0;
    prev_state   = '0;
    decision     = '0;
    seed         = 32'h1237_910e;
    cycle_cnt    = 0;
    tests_run    = 0;
    tests_failed = 0;
    errs_total   = 0;
    reset_dut();

    start_test("no_output_before_fill");
    send_stream(fill_len - 1, 1'b0);
    repeat (40) @(negedge clk);   // Longer than a full traceback and drain
    check_count("bit count", 0, got_bits.size());
    finish_test();

    start_test("first_block");
    send_stream(1, 1'b0);
    compare_output();
    finish_test();

    start_test("long_stream");
    reset_dut();
    send_stream(n_long, 1'b0);
    compare_output();
    check_count("block count", (n_long - tbu_pkg::x_min) / tbu_pkg::blk_len,
                got_bits.size() / tbu_pkg::blk_len);
    finish_test();

    start_test("tight_spacing");
    reset_dut();
    send_stream(n_tight, 1'b1);
    compare_output();
    finish_test();

    start_test("reset_mid_stream");
    reset_dut();
    send_stream(n_pre_reset, 1'b1);
    repeat (3) @(negedge clk);
    reset_dut();
    send_stream(fill_len, 1'b0);
    compare_output();
    check_count("block count", 1, got_bits.size() / tbu_pkg::blk_len);
    finish_test();

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
             errs_total);
    if (tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* tb.f */
source/tbu_pkg.sv
source/survivor_write.sv
source/survivor_mem.sv
source/traceback_engine.sv
source/bit_reorder.sv
source/tbu_top.sv
bench/tbu_props.sv
bench/tbu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbu_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

SOURCES := $(wildcard source/*.sv bench/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Result: FAIL, run ended early"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
